//--- src/hk_defs.svh
`ifndef HK_DEFS_SVH
`define HK_DEFS_SVH

// widths
`define HK_GPIO_W    24
`define HK_ADDR_W    4
`define HK_DATA_W    32

// register map
`define HK_REG_OUT   4'd0
`define HK_REG_DIR   4'd1
`define HK_REG_IN    4'd2
`define HK_REG_ID    4'd3

// fixed block id, ascii "HK" + revision
`define HK_ID_VALUE  32'h484b_0001
// rw + 3 spare + addr + 24 data bits
`define HK_SPI_FRAME 32

`endif

//--- src/hk_pkg.sv
`include "hk_defs.svh"

package hk_pkg;

  // one bit per pin
  typedef logic [`HK_GPIO_W-1:0] gpio_vec_t;
  // register address and data words
  typedef logic [`HK_ADDR_W-1:0] reg_addr_t;
  typedef logic [`HK_DATA_W-1:0] reg_data_t;

  // request from a bus master, held until granted
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
  } bus_req_t;

  // read data, valid in the grant cycle
  typedef struct packed {
    reg_data_t rdata;
  } bus_rsp_t;

  // host port sequencing
  typedef enum logic [1:0] {PORT_IDLE, PORT_WAIT, PORT_DONE} port_state_e;

  // spi frame sequencing
  typedef enum logic [1:0] {SPI_IDLE, SPI_CMD, SPI_ACCESS, SPI_DATA} spi_state_e;

endpackage: hk_pkg

//--- src/host_port.sv
module host_port (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              host_req_i,
  input  hk_pkg::bus_req_t  host_cmd_i,
  output logic              host_done_o,
  output hk_pkg::reg_data_t host_rdata_o,
  output logic              req_valid_o,
  output hk_pkg::bus_req_t  req_o,
  input  logic              gnt_i,
  input  hk_pkg::bus_rsp_t  rsp_i
);
  import hk_pkg::*;

  port_state_e state_q;
  bus_req_t    cmd_q;
  reg_data_t   rdata_q;

  // request -> wait for grant -> done pulse
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= PORT_IDLE;
    end else begin
      case (state_q)
        PORT_IDLE, PORT_DONE: begin
          // a new strobe may land in the done cycle
          state_q <= host_req_i ? PORT_WAIT : PORT_IDLE;
        end
        PORT_WAIT: begin
          if (gnt_i) begin
            state_q <= PORT_DONE;
          end
        end
        default: state_q <= PORT_IDLE;
      endcase
    end
  end

  // command and read data capture
  always_ff @(posedge clk) begin
    if (host_req_i && state_q != PORT_WAIT) begin
      cmd_q <= host_cmd_i;
    end
    if (state_q == PORT_WAIT && gnt_i) begin
      rdata_q <= rsp_i.rdata;
    end
  end

  assign req_valid_o  = (state_q == PORT_WAIT);
  assign req_o        = cmd_q;
  assign host_done_o  = (state_q == PORT_DONE);
  assign host_rdata_o = rdata_q;

  // host may only strobe when no access is outstanding
  a_no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    host_req_i |-> state_q != PORT_WAIT);

endmodule: host_port

//--- src/spi_bridge.sv
`include "hk_defs.svh"

module spi_bridge (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             spi_sck_i,
  input  logic             spi_ss_i,
  input  logic             spi_mosi_i,
  output logic             spi_miso_o,
  output logic             req_valid_o,
  output hk_pkg::bus_req_t req_o,
  input  logic             gnt_i,
  input  hk_pkg::bus_rsp_t rsp_i
);
  import hk_pkg::*;

  localparam int unsigned CMD_BITS  = 8;
  localparam int unsigned DATA_BITS = `HK_SPI_FRAME - CMD_BITS;
  localparam int unsigned CNT_W     = $clog2(`HK_SPI_FRAME + 1);

  logic [2:0]           sck_sync_q;
  logic [2:0]           ss_sync_q;
  logic [1:0]           mosi_sync_q;
  logic                 sck_rise;
  logic                 sck_fall;
  logic                 ss_fall;
  logic                 ss_high;
  logic                 cmd_done;
  logic                 frame_done;
  spi_state_e           state_q;
  logic [CNT_W-1:0]     bit_cnt_q;
  logic [DATA_BITS-1:0] rx_q;
  logic [DATA_BITS-1:0] rx_next;
  logic [DATA_BITS-1:0] tx_q;
  bus_req_t             req_q;
  logic                 miso_q;

  ////////////////////////////////////////////////////////////////////////////
  // pin sync and edge detect
  ////////////////////////////////////////////////////////////////////////////

  // bits [1:0] are the sync pair, bit 2 the edge reference
  assign sck_rise = sck_sync_q[1] & ~sck_sync_q[2];
  assign sck_fall = ~sck_sync_q[1] & sck_sync_q[2];
  assign ss_fall  = ~ss_sync_q[1] & ss_sync_q[2];
  assign ss_high  = ss_sync_q[1];
  // msb first, so new bit enters at the bottom
  assign rx_next  = {rx_q[DATA_BITS-2:0], mosi_sync_q[1]};

  assign cmd_done   = (state_q == SPI_CMD) && sck_rise && (bit_cnt_q == CNT_W'(CMD_BITS - 1));
  assign frame_done = (state_q == SPI_DATA) && sck_rise &&
                      (bit_cnt_q == CNT_W'(`HK_SPI_FRAME - 1));

  ////////////////////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sck_sync_q  <= '0;
      ss_sync_q   <= '1;
      mosi_sync_q <= '0;
      state_q     <= SPI_IDLE;
      bit_cnt_q   <= '0;
      miso_q      <= 1'b0;
    end else begin
      sck_sync_q  <= {sck_sync_q[1:0], spi_sck_i};
      ss_sync_q   <= {ss_sync_q[1:0], spi_ss_i};
      mosi_sync_q <= {mosi_sync_q[0], spi_mosi_i};
      case (state_q)
        SPI_IDLE: begin
          bit_cnt_q <= '0;
          miso_q    <= 1'b0;
          if (ss_fall) begin
            state_q <= SPI_CMD;
          end
        end
        SPI_CMD: begin
          if (ss_high) begin
            state_q <= SPI_IDLE;
          end else if (sck_rise) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            // write waits for data, read fetches now
            if (cmd_done) begin
              state_q <= rx_next[CMD_BITS-1] ? SPI_DATA : SPI_ACCESS;
            end
          end
        end
        SPI_ACCESS: begin
          // held until granted and never aborted
          if (gnt_i) begin
            state_q <= req_q.we ? SPI_IDLE : SPI_DATA;
          end
        end
        SPI_DATA: begin
          if (ss_high) begin
            state_q <= SPI_IDLE;
          end else if (sck_rise) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (frame_done) begin
              state_q <= req_q.we ? SPI_ACCESS : SPI_IDLE;
            end
          end
          // mode 0 drives miso on the falling edge
          if (sck_fall && !req_q.we) begin
            miso_q <= tx_q[DATA_BITS-1];
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // shift registers and captured request
  always_ff @(posedge clk) begin
    if (sck_rise) begin
      rx_q <= rx_next;
    end
    if (cmd_done) begin
      req_q.we    <= rx_next[CMD_BITS-1];
      req_q.addr  <= rx_next[`HK_ADDR_W-1:0];
      req_q.wdata <= '0;
    end
    if (frame_done) begin
      req_q.wdata <= reg_data_t'(rx_next);
    end
    if (state_q == SPI_ACCESS && gnt_i) begin
      tx_q <= rsp_i.rdata[DATA_BITS-1:0];
    end else if (state_q == SPI_DATA && sck_fall) begin
      tx_q <= {tx_q[DATA_BITS-2:0], 1'b0};
    end
  end

  assign req_valid_o = (state_q == SPI_ACCESS);
  assign req_o       = req_q;
  assign spi_miso_o  = miso_q;

  // a bus access fits between two sck edges
  a_access_no_sck_edge: assert property (@(posedge clk) disable iff (!rst_n_i)
    state_q == SPI_ACCESS |-> !sck_rise && !sck_fall);

endmodule: spi_bridge

//--- src/bus_arbiter.sv
module bus_arbiter (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             valid_host_i,
  input  logic             valid_spi_i,
  input  hk_pkg::bus_req_t req_host_i,
  input  hk_pkg::bus_req_t req_spi_i,
  output logic             gnt_host_o,
  output logic             gnt_spi_o,
  output logic             bus_strobe_o,
  output hk_pkg::bus_req_t bus_req_o,
  input  hk_pkg::bus_rsp_t bus_rsp_i,
  output hk_pkg::bus_rsp_t rsp_o
);
  import hk_pkg::*;

  // 1 when spi took the last granted cycle
  logic last_spi_q;

  ////////////////////////////////////////////////////////////////////////////
  // round-robin grant
  ////////////////////////////////////////////////////////////////////////////

  // alone wins, on a tie the loser of last time wins
  assign gnt_host_o = valid_host_i & (~valid_spi_i | last_spi_q);
  assign gnt_spi_o  = valid_spi_i & (~valid_host_i | ~last_spi_q);

  assign bus_strobe_o = gnt_host_o | gnt_spi_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      last_spi_q <= 1'b0;
    end else if (bus_strobe_o) begin
      last_spi_q <= gnt_spi_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // request and response mux
  ////////////////////////////////////////////////////////////////////////////

  // host request doubles as the idle value
  always_comb begin
    bus_req_o = req_host_i;
    if (gnt_spi_o) begin
      bus_req_o = req_spi_i;
    end
  end

  // read data is only sampled by the granted master
  assign rsp_o = bus_rsp_i;

  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(gnt_host_o && gnt_spi_o));

  // a held request is served by the next cycle at the latest
  a_host_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_host_i && !gnt_host_o |=> gnt_host_o);
  a_spi_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_spi_i && !gnt_spi_o |=> gnt_spi_o);

endmodule: bus_arbiter

//--- src/gpio_regs.sv
`include "hk_defs.svh"

module gpio_regs (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              bus_strobe_i,
  input  hk_pkg::bus_req_t  bus_req_i,
  output hk_pkg::bus_rsp_t  bus_rsp_o,
  input  hk_pkg::gpio_vec_t gpio_i,
  output hk_pkg::gpio_vec_t gpio_o,
  output hk_pkg::gpio_vec_t gpio_t_o
);
  import hk_pkg::*;

  localparam int unsigned PAD_W = `HK_DATA_W - `HK_GPIO_W;

  gpio_vec_t out_q;
  gpio_vec_t dir_q;
  gpio_vec_t in_meta_q;
  gpio_vec_t in_sync_q;
  logic      wr_en;

  assign wr_en = bus_strobe_i & bus_req_i.we;

  ////////////////////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////////////////////

  // written at the edge that closes the grant cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_en) begin
      if (bus_req_i.addr == `HK_REG_OUT) begin
        out_q <= bus_req_i.wdata[`HK_GPIO_W-1:0];
      end
      if (bus_req_i.addr == `HK_REG_DIR) begin
        dir_q <= bus_req_i.wdata[`HK_GPIO_W-1:0];
      end
    end
  end

  // two-flop sync of the pad inputs
  always_ff @(posedge clk) begin
    in_meta_q <= gpio_i;
    in_sync_q <= in_meta_q;
  end

  // dir 1 means output and the tristate line is active high
  assign gpio_o   = out_q;
  assign gpio_t_o = ~dir_q;

  // read mux returns zero for holes in the map
  always_comb begin
    case (bus_req_i.addr)
      `HK_REG_OUT: bus_rsp_o.rdata = {{PAD_W{1'b0}}, out_q};
      `HK_REG_DIR: bus_rsp_o.rdata = {{PAD_W{1'b0}}, dir_q};
      `HK_REG_IN:  bus_rsp_o.rdata = {{PAD_W{1'b0}}, in_sync_q};
      `HK_REG_ID:  bus_rsp_o.rdata = `HK_ID_VALUE;
      default:     bus_rsp_o.rdata = '0;
    endcase
  end

endmodule: gpio_regs

//--- src/hk_system.sv
module hk_system (
  input  logic              clk,
  input  logic              rst_n_i,
  // host register port
  input  logic              host_req_i,
  input  hk_pkg::bus_req_t  host_cmd_i,
  output logic              host_done_o,
  output hk_pkg::reg_data_t host_rdata_o,
  // spi slave
  input  logic              spi_sck_i,
  input  logic              spi_ss_i,
  input  logic              spi_mosi_i,
  output logic              spi_miso_o,
  // gpio pins
  input  hk_pkg::gpio_vec_t gpio_i,
  output hk_pkg::gpio_vec_t gpio_o,
  output hk_pkg::gpio_vec_t gpio_t_o
);

  // master side
  logic             host_valid;
  logic             host_gnt;
  hk_pkg::bus_req_t host_req;
  logic             spi_valid;
  logic             spi_gnt;
  hk_pkg::bus_req_t spi_req;
  hk_pkg::bus_rsp_t arb_rsp;
  // shared bus to the slave
  logic             bus_strobe;
  hk_pkg::bus_req_t bus_req;
  hk_pkg::bus_rsp_t bus_rsp;

  host_port host_port_i (
    .clk, .rst_n_i, .host_req_i, .host_cmd_i, .host_done_o, .host_rdata_o,
    .req_valid_o (host_valid), .req_o (host_req), .gnt_i (host_gnt), .rsp_i (arb_rsp)
  );

  spi_bridge spi_bridge_i (
    .clk, .rst_n_i, .spi_sck_i, .spi_ss_i, .spi_mosi_i, .spi_miso_o,
    .req_valid_o (spi_valid), .req_o (spi_req), .gnt_i (spi_gnt), .rsp_i (arb_rsp)
  );

  bus_arbiter bus_arbiter_i (
    .clk, .rst_n_i,
    .valid_host_i (host_valid), .valid_spi_i (spi_valid),
    .req_host_i (host_req), .req_spi_i (spi_req),
    .gnt_host_o (host_gnt), .gnt_spi_o (spi_gnt),
    .bus_strobe_o (bus_strobe), .bus_req_o (bus_req),
    .bus_rsp_i (bus_rsp), .rsp_o (arb_rsp)
  );

  gpio_regs gpio_regs_i (
    .clk, .rst_n_i,
    .bus_strobe_i (bus_strobe), .bus_req_i (bus_req), .bus_rsp_o (bus_rsp),
    .gpio_i, .gpio_o, .gpio_t_o
  );

endmodule: hk_system

//--- tb/hk_system_tb.sv
`include "hk_defs.svh"

module hk_system_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import hk_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int DRV          = 5;
  // 16 clk periods per sck bit
  localparam int SCK_HALF     = 8;
  localparam int HOST_TIMEOUT = 8;
  localparam reg_data_t PIN_MASK = (32'h1 << `HK_GPIO_W) - 1;

  logic      clk = 1'b0;
  logic      rst_n_i;
  logic      host_req_i;
  bus_req_t  host_cmd_i;
  logic      host_done_o;
  reg_data_t host_rdata_o;
  logic      spi_sck_i;
  logic      spi_ss_i;
  logic      spi_mosi_i;
  logic      spi_miso_o;
  gpio_vec_t gpio_i;
  gpio_vec_t gpio_o;
  gpio_vec_t gpio_t_o;

  // test table from the golden file
  string     t_name[$];
  string     t_op[$];
  string     t_dtok[$];
  string     t_etok[$];
  reg_addr_t t_addr[$];

  logic [31:0] lfsr_q = 32'h847e_880c;
  reg_data_t   data_prev = '0;
  bit          loaded = 1'b0;
  int          n_fail = 0;
  int          n_pass = 0;
  // marks the last sck rise of a frame
  event        last_rise_ev;

  hk_system dut_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic reg_data_t random_word();
    reg_data_t v;
    v = '0;
    for (int i = 0; i < `HK_DATA_W; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[`HK_DATA_W-2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic reg_data_t hex_token(string tok);
    reg_data_t v;
    v = '0;
    void'($sscanf(tok, "%h", v));
    return v;
  endfunction

  // inputs change a few ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #DRV;
  endtask

  task automatic wait_cycles(int n);
    repeat (n) next_cycle();
  endtask

  task automatic report_mismatch(string name, reg_data_t exp, reg_data_t act);
    $display("error %s: expected %h, actual %h", name, exp, act);
  endtask

  // strobe one command, then wait for done
  task automatic host_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                             output reg_data_t rdata, output int lat, output bit timed_out);
    bus_req_t cmd;
    cmd.we      = we;
    cmd.addr    = addr;
    cmd.wdata   = wdata;
    host_cmd_i  = cmd;
    host_req_i  = 1'b1;
    rdata       = '0;
    timed_out   = 1'b0;
    next_cycle();
    host_req_i  = 1'b0;
    lat         = 1;
    while (!host_done_o && lat < HOST_TIMEOUT) begin
      next_cycle();
      lat++;
    end
    if (!host_done_o) begin
      timed_out = 1'b1;
    end else begin
      rdata = host_rdata_o;
    end
  endtask

  // mode 0 master, msb first; nbits below 32 cuts the frame short
  task automatic spi_frame(input logic [31:0] frame, input int nbits,
                           output logic [`HK_GPIO_W-1:0] rx);
    rx       = '0;
    spi_ss_i = 1'b0;
    wait_cycles(SCK_HALF);
    for (int i = 0; i < nbits; i++) begin
      spi_mosi_i = frame[31-i];
      wait_cycles(SCK_HALF);
      spi_sck_i = 1'b1;
      // slave data only after the 8 command bits
      if (i >= 8) begin
        rx = {rx[`HK_GPIO_W-2:0], spi_miso_o};
      end
      if (i == nbits - 1) begin
        -> last_rise_ev;
      end
      wait_cycles(SCK_HALF);
      spi_sck_i = 1'b0;
    end
    wait_cycles(SCK_HALF);
    spi_ss_i = 1'b1;
    wait_cycles(SCK_HALF);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    longint limit_ns;
    wait (loaded);
    // every test bounded by one full frame, twice over
    limit_ns = (64 + longint'(t_name.size()) * `HK_SPI_FRAME * 16 * 2) * CLK_PERIOD;
    #(limit_ns);
    $display("watchdog expired at %0t, tests did not finish", $time);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                   fd;
    int                   fields;
    int                   lat;
    string                line;
    string                name;
    string                op;
    string                dtok;
    string                etok;
    logic [31:0]          addr_v;
    reg_data_t            data;
    reg_data_t            exp;
    reg_data_t            rd;
    logic [`HK_GPIO_W-1:0] rx;
    bit                   has_exp;
    bit                   ok;
    bit                   tmo;

    rst_n_i    = 1'b0;
    host_req_i = 1'b0;
    host_cmd_i = '0;
    spi_sck_i  = 1'b0;
    spi_ss_i   = 1'b1;
    spi_mosi_i = 1'b0;
    gpio_i     = '0;

    fd = $fopen("tb/hk_system_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/hk_system_golden.txt");
      n_fail++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // skip comment lines
        if (line.len() == 0 || line.getc(0) == 8'h23) begin
          continue;
        end
        fields = $sscanf(line, "%s %s %h %s %s", name, op, addr_v, dtok, etok);
        if (fields == 5) begin
          t_name.push_back(name);
          t_op.push_back(op);
          t_addr.push_back(addr_v[`HK_ADDR_W-1:0]);
          t_dtok.push_back(dtok);
          t_etok.push_back(etok);
        end
      end
      $fclose(fd);
      if (t_name.size() == 0) begin
        $display("golden file holds no tests");
        n_fail++;
      end
    end
    loaded = 1'b1;

    repeat (16) @(posedge clk);
    #DRV;
    rst_n_i = 1'b1;
    wait_cycles(2);

    foreach (t_name[i]) begin
      ok = 1'b1;
      // data and expected value
      if (t_dtok[i] == "rnd") begin
        data = random_word();
      end else if (t_dtok[i] == "prev") begin
        data = data_prev;
      end else begin
        data = hex_token(t_dtok[i]);
      end
      has_exp = (t_etok[i] != "-");
      if (t_etok[i] == "prev") begin
        exp = data_prev & PIN_MASK;
      end else begin
        exp = hex_token(t_etok[i]);
      end

      case (t_op[i])
        "hw", "hr": begin
          host_access(t_op[i] == "hw", t_addr[i], data, rd, lat, tmo);
          if (tmo) begin
            $display("test %s: host access got no done pulse", t_name[i]);
            ok = 1'b0;
          end else if (has_exp && rd !== exp) begin
            report_mismatch(t_name[i], exp, rd);
            ok = 1'b0;
          end
        end
        "sw", "cut": begin
          spi_frame({1'b1, 3'b000, t_addr[i], data[`HK_GPIO_W-1:0]},
                    t_op[i] == "cut" ? 20 : `HK_SPI_FRAME, rx);
        end
        "sr": begin
          spi_frame({1'b0, 3'b000, t_addr[i], {`HK_GPIO_W{1'b0}}}, `HK_SPI_FRAME, rx);
          if (has_exp && reg_data_t'(rx) !== exp) begin
            report_mismatch(t_name[i], exp, reg_data_t'(rx));
            ok = 1'b0;
          end
        end
        "pin": begin
          gpio_i = data[`HK_GPIO_W-1:0];
          // room for the two-flop sync
          wait_cycles(4);
        end
        "po": begin
          if (reg_data_t'(gpio_o) !== exp) begin
            report_mismatch(t_name[i], exp, reg_data_t'(gpio_o));
            ok = 1'b0;
          end
        end
        "pt": begin
          if (reg_data_t'(gpio_t_o) !== exp) begin
            report_mismatch(t_name[i], exp, reg_data_t'(gpio_t_o));
            ok = 1'b0;
          end
        end
        "pair": begin
          // spi write and host id read raise their requests in the same cycle
          fork
            spi_frame({1'b1, 3'b000, t_addr[i], data[`HK_GPIO_W-1:0]}, `HK_SPI_FRAME, rx);
            begin
              @(last_rise_ev);
              // sck sync plus frame decode take two edges
              repeat (2) @(posedge clk);
              #DRV;
              host_access(1'b0, `HK_REG_ID, '0, rd, lat, tmo);
            end
          join
          if (tmo) begin
            $display("test %s: host access got no done pulse", t_name[i]);
            ok = 1'b0;
          end else if (rd !== exp) begin
            report_mismatch(t_name[i], exp, rd);
            ok = 1'b0;
          end else if (lat > 3) begin
            $display("test %s: host done took %0d cycles, limit is 3", t_name[i], lat);
            ok = 1'b0;
          end
        end
        default: begin
          $display("test %s: unknown operation %s", t_name[i], t_op[i]);
          ok = 1'b0;
        end
      endcase

      // writes set the reference for later lines
      if (t_op[i] inside {"hw", "sw", "pin", "pair"}) begin
        data_prev = data;
      end
      if (ok) begin
        n_pass++;
      end else begin
        n_fail++;
      end
      $display("test %-12s %s", t_name[i], ok ? "ok" : "FAILED");
      wait_cycles(2);
    end

    $display("%0d tests, %0d passed, %0d failed", t_name.size(), n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule: hk_system_tb

//--- hk_system.f
+incdir+src
src/hk_pkg.sv
src/host_port.sv
src/spi_bridge.sv
src/bus_arbiter.sv
src/gpio_regs.sv
src/hk_system.sv
tb/hk_system_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hk_system testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/hk_system_sim

verilator --binary --timing --assert -Wno-fatal \
  -f hk_system.f --top-module hk_system_tb -o hk_system_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb/hk_system_golden.txt
# name op addr data expected; op is hw hr sw sr pin po pt pair cut, addr/data/expected in hex
# data rnd = next lfsr word, prev = last written data; expected prev = that data masked to 24 bits, - = none
rst_out      po   0 0          000000
rst_dir      pt   0 0          ffffff
rst_id       hr   3 0          484b0001
out_wr       hw   0 rnd        -
out_pins     po   0 0          prev
out_rd       hr   0 0          prev
dir_wr       hw   1 ffa55a5a   -
dir_pins     pt   0 0          005aa5a5
dir_rd       hr   1 0          00a55a5a
spi_wr       sw   0 rnd        -
spi_host_rd  hr   0 0          prev
host_wr      hw   0 rnd        -
host_spi_rd  sr   0 0          prev
spi_id       sr   3 0          004b0001
pin_in       pin  0 rnd        -
pin_host_rd  hr   2 0          prev
pin_spi_rd   sr   2 0          prev
pair_id      pair 0 0013579b   484b0001
pair_out     hr   0 0          prev
bad_rd       hr   9 0          00000000
bad_wr       hw   9 12345678   -
bad_out      hr   0 0          0013579b
bad_dir      hr   1 0          00a55a5a
cut_frame    cut  0 00abcdef   -
cut_out      hr   0 0          0013579b
cut_pins     po   0 0          0013579b
after_cut    sr   0 0          0013579b
